//--- hdl/hctl_pkg.sv
`default_nettype none

package hctl_pkg;

    localparam int xlen = 32;

    typedef logic [4:0]      reg_idx_t;
    typedef logic [xlen-1:0] word_t;

    // register sources and operand values of the instruction in decode.
    typedef struct packed {
        logic     valid;
        reg_idx_t rs1;
        reg_idx_t rs2;
        word_t    rs1_value;
        word_t    rs2_value;
    } idu_src_t;

    // bit 0 of result carries the branch compare outcome.
    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_wen;
        logic     mem_ren;
        word_t    pc;
        word_t    imm;
        word_t    result;
    } exu_info_t;

    typedef struct packed {
        logic     valid;
        reg_idx_t rd;
        logic     reg_wen;
        logic     mem_ren;
        word_t    ex_result;
        word_t    rdata;
    } mem_info_t;

    // control decoded for the instruction in execute.
    typedef struct packed {
        logic branch;
        logic jump;
        logic mret;
        logic ecall;
        logic fence_i;
    } ctrl_flags_t;

    // encodings match the operand choice codes used by the pipeline.
    typedef enum logic [1:0] {
        fwd_none     = 2'b00,
        fwd_exu      = 2'b01,
        fwd_mem_alu  = 2'b10,
        fwd_mem_load = 2'b11
    } fwd_sel_e;

    typedef enum logic {
        csr_mtvec = 1'b0,
        csr_mepc  = 1'b1
    } csr_sel_e;

    typedef struct packed {
        logic  valid;
        word_t target;
        logic  flush;
        logic  icache_clr;
    } redirect_t;

endpackage

`default_nettype wire

//--- hdl/hazard_detect.sv
`timescale 1ns/1ps
`default_nettype none

module hazard_detect import hctl_pkg::*; (
    input  idu_src_t  idu,
    input  exu_info_t exu,
    input  mem_info_t mem,
    output fwd_sel_e  rs1_sel,
    output fwd_sel_e  rs2_sel,
    output logic      stall
);

    logic exu_writes;
    logic mem_writes;
    logic rs1_load_use;
    logic rs2_load_use;

    // x0 never forwards, and a rd of zero never matches a live source.
    assign exu_writes = exu.valid && exu.reg_wen && (exu.rd != '0);
    assign mem_writes = mem.valid && mem.reg_wen && (mem.rd != '0);

    // true when the source needs a load result that is still in execute.
    function automatic logic load_use(input reg_idx_t rs);
        logic hit;
        hit = idu.valid && (rs != '0) && exu_writes && (exu.rd == rs);
        return hit && exu.mem_ren;
    endfunction

    // the younger writer in execute takes priority over memory.
    function automatic fwd_sel_e source_sel(input reg_idx_t rs);
        fwd_sel_e sel;
        sel = fwd_none;
        if (idu.valid && (rs != '0)) begin
            if (exu_writes && (exu.rd == rs)) begin
                if (!exu.mem_ren) begin
                    sel = fwd_exu;
                end
            end else if (mem_writes && (mem.rd == rs)) begin
                if (mem.mem_ren) begin
                    sel = fwd_mem_load;
                end else begin
                    sel = fwd_mem_alu;
                end
            end
        end
        return sel;
    endfunction

    always_comb begin
        rs1_sel      = source_sel(idu.rs1);
        rs2_sel      = source_sel(idu.rs2);
        rs1_load_use = load_use(idu.rs1);
        rs2_load_use = load_use(idu.rs2);
    end

    assign stall = rs1_load_use || rs2_load_use;

endmodule

`default_nettype wire

//--- hdl/operand_forward.sv
`timescale 1ns/1ps
`default_nettype none

module operand_forward import hctl_pkg::*; (
    input  idu_src_t  idu,
    input  word_t     exu_result,
    input  mem_info_t mem,
    input  fwd_sel_e  rs1_sel,
    input  fwd_sel_e  rs2_sel,
    output word_t     rs1_fwd,
    output word_t     rs2_fwd
);

    // one four-way choice between the decode value and the three bypass paths.
    function automatic word_t pick(input fwd_sel_e sel, input word_t decode_value);
        word_t value;
        case (sel)
            fwd_exu: begin
                value = exu_result;
            end
            fwd_mem_alu: begin
                value = mem.ex_result;
            end
            fwd_mem_load: begin
                value = mem.rdata;
            end
            default: begin
                value = decode_value;
            end
        endcase
        return value;
    endfunction

    always_comb begin
        rs1_fwd = pick(rs1_sel, idu.rs1_value);
        rs2_fwd = pick(rs2_sel, idu.rs2_value);
    end

endmodule

`default_nettype wire

//--- hdl/redirect_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module redirect_ctrl import hctl_pkg::*; (
    input  exu_info_t   exu,
    input  ctrl_flags_t flags,
    input  word_t       mtvec,
    input  word_t       mepc,
    input  logic        stall,
    output redirect_t   redirect,
    output logic        exu_bubble
);

    logic  branch_taken;
    logic  take;
    word_t target;

    // flags only mean something while execute holds a valid instruction.
    assign branch_taken = flags.branch && exu.result[0];

    assign take = exu.valid && (flags.jump || flags.fence_i || flags.ecall ||
                                flags.mret || branch_taken);

    always_comb begin
        if (flags.jump) begin
            target = exu.result;
        end else if (flags.branch) begin
            target = exu.pc + exu.imm;
        end else if (flags.fence_i) begin
            // refetch the instruction after fence.i once the cache is cleared.
            target = exu.pc + word_t'(4);
        end else if (flags.mret) begin
            target = mepc;
        end else begin
            target = mtvec;
        end
    end

    always_comb begin
        redirect.valid      = take;
        redirect.target     = take ? target : '0;
        redirect.flush      = take;
        redirect.icache_clr = exu.valid && flags.fence_i;
    end

    // a flush or a load-use stall both turn the next execute slot into a bubble.
    assign exu_bubble = redirect.flush || stall;

endmodule

`default_nettype wire

//--- hdl/trap_csr.sv
`timescale 1ns/1ps
`default_nettype none

module trap_csr import hctl_pkg::*; #(
    parameter word_t mtvec_reset = 32'h8000_0100
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     csr_we,
    input  csr_sel_e csr_sel,
    input  word_t    csr_wdata,
    input  logic     ecall_take,
    input  word_t    epc,
    output word_t    mtvec,
    output word_t    mepc
);

    word_t mtvec_q;
    word_t mepc_q;
    logic  mtvec_we;
    logic  mepc_we;

    assign mtvec_we = csr_we && (csr_sel == csr_mtvec);
    assign mepc_we  = csr_we && (csr_sel == csr_mepc);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mtvec_q <= mtvec_reset;
        end else if (mtvec_we) begin
            mtvec_q <= csr_wdata;
        end
    end

    // the trap entry overrides a software write to mepc in the same cycle.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mepc_q <= '0;
        end else if (ecall_take) begin
            mepc_q <= epc;
        end else if (mepc_we) begin
            mepc_q <= csr_wdata;
        end
    end

    assign mtvec = mtvec_q;
    assign mepc  = mepc_q;

endmodule

`default_nettype wire

//--- hdl/pc_sequencer.sv
`timescale 1ns/1ps
`default_nettype none

module pc_sequencer import hctl_pkg::*; #(
    parameter word_t reset_pc = 32'h8000_0000
) (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      stall,
    input  redirect_t redirect,
    output word_t     fetch_pc
);

    word_t pc_q;
    word_t pc_next;

    // a redirect from execute outranks a load-use hold.
    always_comb begin
        if (redirect.valid) begin
            pc_next = redirect.target;
        end else if (stall) begin
            pc_next = pc_q;
        end else begin
            pc_next = pc_q + word_t'(4);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pc_q <= reset_pc;
        end else begin
            pc_q <= pc_next;
        end
    end

    assign fetch_pc = pc_q;

endmodule

`default_nettype wire

//--- hdl/hctl_top.sv
`timescale 1ns/1ps
`default_nettype none

module hctl_top import hctl_pkg::*; #(
    parameter word_t reset_pc    = 32'h8000_0000,
    parameter word_t mtvec_reset = 32'h8000_0100
) (
    input  logic        clk,
    input  logic        rst_n,
    input  idu_src_t    idu,
    input  exu_info_t   exu,
    input  ctrl_flags_t flags,
    input  mem_info_t   mem,
    input  logic        csr_we,
    input  csr_sel_e    csr_sel,
    input  word_t       csr_wdata,
    output word_t       rs1_fwd,
    output word_t       rs2_fwd,
    output logic        stall,
    output logic        exu_bubble,
    output redirect_t   redirect,
    output word_t       fetch_pc
);

    fwd_sel_e rs1_sel;
    fwd_sel_e rs2_sel;
    word_t    mtvec;
    word_t    mepc;
    logic     ecall_take;

    // redirect.valid already carries the execute valid gate.
    assign ecall_take = redirect.valid && flags.ecall;

    hazard_detect hazard_detect0 (
        .idu     (idu),
        .exu     (exu),
        .mem     (mem),
        .rs1_sel (rs1_sel),
        .rs2_sel (rs2_sel),
        .stall   (stall)
    );

    operand_forward operand_forward0 (
        .idu        (idu),
        .exu_result (exu.result),
        .mem        (mem),
        .rs1_sel    (rs1_sel),
        .rs2_sel    (rs2_sel),
        .rs1_fwd    (rs1_fwd),
        .rs2_fwd    (rs2_fwd)
    );

    redirect_ctrl redirect_ctrl0 (
        .exu        (exu),
        .flags      (flags),
        .mtvec      (mtvec),
        .mepc       (mepc),
        .stall      (stall),
        .redirect   (redirect),
        .exu_bubble (exu_bubble)
    );

    trap_csr #(
        .mtvec_reset (mtvec_reset)
    ) trap_csr0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .csr_we     (csr_we),
        .csr_sel    (csr_sel),
        .csr_wdata  (csr_wdata),
        .ecall_take (ecall_take),
        .epc        (exu.pc),
        .mtvec      (mtvec),
        .mepc       (mepc)
    );

    pc_sequencer #(
        .reset_pc (reset_pc)
    ) pc_sequencer0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .stall    (stall),
        .redirect (redirect),
        .fetch_pc (fetch_pc)
    );

endmodule

`default_nettype wire

//--- bench/hctl_tb.sv
`timescale 1ns/1ps
`default_nettype none

module hctl_tb import hctl_pkg::*; ();

    localparam word_t reset_pc      = 32'h8000_0000;
    localparam word_t mtvec_reset   = 32'h8000_0100;
    localparam int    clk_period    = 20;
    localparam int    test_cycles   = 40;
    localparam int    margin_cycles = 20;

    logic        clk;
    logic        rst_n;
    idu_src_t    idu;
    exu_info_t   exu;
    ctrl_flags_t flags;
    mem_info_t   mem;
    logic        csr_we;
    csr_sel_e    csr_sel;
    word_t       csr_wdata;
    word_t       rs1_fwd;
    word_t       rs2_fwd;
    logic        stall;
    logic        exu_bubble;
    redirect_t   redirect;
    word_t       fetch_pc;

    integer seed;
    word_t  exp_pc;

    hctl_top #(
        .reset_pc    (reset_pc),
        .mtvec_reset (mtvec_reset)
    ) dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .idu        (idu),
        .exu        (exu),
        .flags      (flags),
        .mem        (mem),
        .csr_we     (csr_we),
        .csr_sel    (csr_sel),
        .csr_wdata  (csr_wdata),
        .rs1_fwd    (rs1_fwd),
        .rs2_fwd    (rs2_fwd),
        .stall      (stall),
        .exu_bubble (exu_bubble),
        .redirect   (redirect),
        .fetch_pc   (fetch_pc)
    );

    always #(clk_period / 2) clk = ~clk;

    task automatic stop_on_error();
        $display("TESTBENCH FAILED");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare_word(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_bit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            stop_on_error();
        end
    endtask

    task automatic compare_redirect(input string name, input redirect_t got,
                                    input redirect_t exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got v=%b t=%h f=%b i=%b expected v=%b t=%h f=%b i=%b",
                     $time, name, got.valid, got.target, got.flush, got.icache_clr,
                     exp.valid, exp.target, exp.flush, exp.icache_clr);
            stop_on_error();
        end
    endtask

    task automatic clear_inputs();
        idu       = '0;
        exu       = '0;
        flags     = '0;
        mem       = '0;
        csr_we    = 1'b0;
        csr_sel   = csr_mtvec;
        csr_wdata = '0;
    endtask

    // inputs change on the falling edge, so each step ends on one.
    task automatic step_and_check_pc(input word_t next_pc);
        exp_pc = next_pc;
        @(posedge clk);
        @(negedge clk);
        compare_word("fetch_pc", fetch_pc, exp_pc);
    endtask

    function automatic exu_info_t make_exu(input reg_idx_t rd, input logic reg_wen,
                                           input logic mem_ren, input word_t pc,
                                           input word_t imm, input word_t result);
        exu_info_t e;
        e.valid   = 1'b1;
        e.rd      = rd;
        e.reg_wen = reg_wen;
        e.mem_ren = mem_ren;
        e.pc      = pc;
        e.imm     = imm;
        e.result  = result;
        return e;
    endfunction

    function automatic mem_info_t make_mem(input reg_idx_t rd, input logic reg_wen,
                                           input logic mem_ren, input word_t ex_result,
                                           input word_t rdata);
        mem_info_t m;
        m.valid     = 1'b1;
        m.rd        = rd;
        m.reg_wen   = reg_wen;
        m.mem_ren   = mem_ren;
        m.ex_result = ex_result;
        m.rdata     = rdata;
        return m;
    endfunction

    // side 0 puts the register on rs1, side 1 on rs2; the other source is x9.
    task automatic load_sources(input int side, input reg_idx_t r);
        idu.valid     = 1'b1;
        idu.rs1       = (side == 0) ? r : 5'd9;
        idu.rs2       = (side == 1) ? r : 5'd9;
        idu.rs1_value = $random(seed);
        idu.rs2_value = $random(seed);
    endtask

    task automatic check_forward(input string name, input int side, input word_t exp);
        word_t exp_rs1;
        word_t exp_rs2;
        exp_rs1 = (side == 0) ? exp : idu.rs1_value;
        exp_rs2 = (side == 1) ? exp : idu.rs2_value;
        #2;
        compare_word({name, " rs1_fwd"}, rs1_fwd, exp_rs1);
        compare_word({name, " rs2_fwd"}, rs2_fwd, exp_rs2);
        compare_bit({name, " stall"}, stall, 1'b0);
        step_and_check_pc(exp_pc + 32'd4);
    endtask

    task automatic check_redirect_case(input string name, input logic exp_take,
                                       input word_t exp_target, input logic exp_icache);
        redirect_t exp_rd;
        exp_rd.valid      = exp_take;
        exp_rd.target     = exp_take ? exp_target : '0;
        exp_rd.flush      = exp_take;
        exp_rd.icache_clr = exp_icache;
        #2;
        compare_redirect(name, redirect, exp_rd);
        compare_bit({name, " exu_bubble"}, exu_bubble, exp_take);
        if (exp_take) begin
            step_and_check_pc(exp_target);
        end else begin
            step_and_check_pc(exp_pc + 32'd4);
        end
    endtask

    task automatic test_reset_state();
        compare_word("fetch_pc after reset", fetch_pc, reset_pc);
        compare_redirect("redirect after reset", redirect, '0);
        compare_bit("stall after reset", stall, 1'b0);
        compare_bit("exu_bubble after reset", exu_bubble, 1'b0);
        repeat (3) begin
            step_and_check_pc(exp_pc + 32'd4);
        end
    endtask

    task automatic test_forwarding();
        word_t exu_val;
        word_t alu_val;
        word_t load_val;
        for (int side = 0; side < 2; side++) begin
            exu_val  = $random(seed);
            alu_val  = $random(seed);
            load_val = $random(seed);
            clear_inputs();
            load_sources(side, 5'd7);
            exu = make_exu(5'd7, 1'b1, 1'b0, '0, '0, exu_val);
            check_forward("exu match", side, exu_val);
            clear_inputs();
            load_sources(side, 5'd7);
            mem = make_mem(5'd7, 1'b1, 1'b0, alu_val, load_val);
            check_forward("mem alu match", side, alu_val);
            clear_inputs();
            load_sources(side, 5'd7);
            mem = make_mem(5'd7, 1'b1, 1'b1, alu_val, load_val);
            check_forward("mem load match", side, load_val);
            clear_inputs();
            load_sources(side, 5'd7);
            exu = make_exu(5'd7, 1'b1, 1'b0, '0, '0, exu_val);
            mem = make_mem(5'd7, 1'b1, 1'b1, alu_val, load_val);
            check_forward("exu and mem match", side, exu_val);
            // x0 as source and destination must keep the decode value.
            clear_inputs();
            load_sources(side, 5'd0);
            exu = make_exu(5'd0, 1'b1, 1'b0, '0, '0, exu_val);
            mem = make_mem(5'd0, 1'b1, 1'b0, alu_val, load_val);
            check_forward("rd zero", side, (side == 0) ? idu.rs1_value : idu.rs2_value);
            clear_inputs();
            load_sources(side, 5'd7);
            exu = make_exu(5'd7, 1'b0, 1'b0, '0, '0, exu_val);
            mem = make_mem(5'd7, 1'b0, 1'b0, alu_val, load_val);
            check_forward("no write enable", side, (side == 0) ? idu.rs1_value : idu.rs2_value);
        end
    endtask

    task automatic test_load_use();
        clear_inputs();
        load_sources(1, 5'd12);
        idu.rs1 = 5'd3;
        exu = make_exu(5'd12, 1'b1, 1'b1, 32'h8000_0200, '0, $random(seed));
        #2;
        compare_bit("load-use stall", stall, 1'b1);
        compare_bit("load-use exu_bubble", exu_bubble, 1'b1);
        compare_redirect("load-use redirect", redirect, '0);
        step_and_check_pc(exp_pc);
        #2;
        compare_bit("held load-use stall", stall, 1'b1);
        step_and_check_pc(exp_pc);
        exu.rd = 5'd13;
        #2;
        compare_bit("cleared stall", stall, 1'b0);
        compare_bit("cleared exu_bubble", exu_bubble, 1'b0);
        step_and_check_pc(exp_pc + 32'd4);
    endtask

    task automatic test_redirects();
        word_t branch_imm;
        branch_imm = $random(seed) & 32'h0000_0ffc;
        clear_inputs();
        exu = make_exu(5'd1, 1'b1, 1'b0, 32'h8000_1000, 32'h0000_0020, 32'h8000_2468);
        flags.jump = 1'b1;
        check_redirect_case("jump", 1'b1, 32'h8000_2468, 1'b0);
        clear_inputs();
        exu = make_exu(5'd0, 1'b0, 1'b0, 32'h8000_3000, branch_imm, 32'h0000_0001);
        flags.branch = 1'b1;
        check_redirect_case("taken branch", 1'b1, 32'h8000_3000 + branch_imm, 1'b0);
        clear_inputs();
        exu = make_exu(5'd0, 1'b0, 1'b0, 32'h8000_3100, branch_imm, 32'h0000_0000);
        flags.branch = 1'b1;
        check_redirect_case("not-taken branch", 1'b0, '0, 1'b0);
        clear_inputs();
        exu = make_exu(5'd0, 1'b0, 1'b0, 32'h8000_4000, '0, '0);
        flags.fence_i = 1'b1;
        check_redirect_case("fence_i", 1'b1, 32'h8000_4004, 1'b1);
        clear_inputs();
        exu = make_exu(5'd1, 1'b1, 1'b0, 32'h8000_4100, '0, 32'h8000_9000);
        exu.valid     = 1'b0;
        flags.jump    = 1'b1;
        flags.fence_i = 1'b1;
        check_redirect_case("invalid exu", 1'b0, '0, 1'b0);
    endtask

    task automatic test_trap_csrs();
        word_t new_mtvec;
        new_mtvec = ($random(seed) & 32'h0000_fffc) | 32'h8000_0000;
        // before any software write the trap vector is still its reset value.
        clear_inputs();
        exu = make_exu(5'd0, 1'b0, 1'b0, 32'h8000_4800, '0, '0);
        flags.ecall = 1'b1;
        check_redirect_case("ecall at reset mtvec", 1'b1, mtvec_reset, 1'b0);
        clear_inputs();
        csr_we    = 1'b1;
        csr_sel   = csr_mtvec;
        csr_wdata = new_mtvec;
        step_and_check_pc(exp_pc + 32'd4);
        clear_inputs();
        exu = make_exu(5'd0, 1'b0, 1'b0, 32'h8000_5000, '0, '0);
        flags.ecall = 1'b1;
        check_redirect_case("ecall", 1'b1, new_mtvec, 1'b0);
        clear_inputs();
        exu = make_exu(5'd0, 1'b0, 1'b0, 32'h8000_5100, '0, '0);
        flags.mret = 1'b1;
        check_redirect_case("mret after ecall", 1'b1, 32'h8000_5000, 1'b0);
        clear_inputs();
        exu = make_exu(5'd0, 1'b0, 1'b0, 32'h8000_6000, '0, '0);
        flags.ecall = 1'b1;
        csr_we      = 1'b1;
        csr_sel     = csr_mepc;
        csr_wdata   = 32'h1234_5678;
        check_redirect_case("ecall with mepc write", 1'b1, new_mtvec, 1'b0);
        clear_inputs();
        exu = make_exu(5'd0, 1'b0, 1'b0, 32'h8000_6100, '0, '0);
        flags.mret = 1'b1;
        check_redirect_case("mret after contended write", 1'b1, 32'h8000_6000, 1'b0);
        clear_inputs();
        csr_we    = 1'b1;
        csr_sel   = csr_mepc;
        csr_wdata = 32'h8000_7000;
        step_and_check_pc(exp_pc + 32'd4);
        clear_inputs();
        exu = make_exu(5'd0, 1'b0, 1'b0, 32'h8000_7100, '0, '0);
        flags.mret = 1'b1;
        check_redirect_case("mret after software write", 1'b1, 32'h8000_7000, 1'b0);
        clear_inputs();
    endtask

    initial begin
        seed   = 32'hc9798ed0;
        clk    = 1'b0;
        rst_n  = 1'b0;
        clear_inputs();
        exp_pc = reset_pc;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        test_reset_state();
        test_forwarding();
        test_load_use();
        test_redirects();
        test_trap_csrs();
        $display("TESTBENCH PASSED");
        $finish;
    end

    initial begin
        #((test_cycles + margin_cycles) * clk_period);
        $display("watchdog expired before the tests finished");
        $display("TESTBENCH FAILED");
        $fatal(1, "simulation timeout");
    end

endmodule

`default_nettype wire

//--- hctl.f
hdl/hctl_pkg.sv
hdl/hazard_detect.sv
hdl/operand_forward.sv
hdl/redirect_ctrl.sv
hdl/trap_csr.sv
hdl/pc_sequencer.sv
hdl/hctl_top.sv
bench/hctl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --timescale 1ns/1ps --top-module hctl_tb \
    -f hctl.f -o hctl_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/hctl_sim > "$log" 2>&1
run_status=$?
cat "$log"

if grep -q "TESTBENCH FAILED" "$log"; then
    echo "simulation reported a failure"
    exit 1
fi

if [ $run_status -ne 0 ]; then
    echo "simulator exited with status $run_status"
    exit 1
fi

echo "simulation finished without failure"
exit 0
